/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = idu_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

/* design/idu_count.sv */
module idu_count (
	input  logic                         clk4,
	input  logic                         arst_n,
	input  logic                         dec_valid,
	input  logic [idu_pkg::pair_w-1:0]   dec_pair,
	input  logic [idu_pkg::word_w-1:0]   dec_operand,
	input  logic                         dec_inc,
	input  logic                         dec_dec,
	input  logic                         dec_split,
	input  logic                         dec_addr,
	output logic                         ex_valid,
	output logic [idu_pkg::pair_w-1:0]   ex_pair,
	output logic [idu_pkg::word_w-1:0]   ex_value,
	output logic                         ex_addr,
	output logic [idu_pkg::word_w-1:0]   ex_operand
);
	import idu_pkg::*;

	logic              step;       // Any step selected
	logic [word_w-1:0] operand;    // Value actually stepped
	logic [word_w-1:0] step_val;   // Chain output

	assign step = dec_inc | dec_dec;

	// The command one ahead sits in the ex register now
	// Its result is newer than anything decode could see
	// LD carries its own immediate, so no override there
	assign operand = (step && ex_valid && ex_pair == dec_pair) ? ex_value : dec_operand;

	// Bit cells with ripple carry
	// No select at all gives a zero carry-in, so the value passes unchanged
	for (genvar i = 0; i < word_w; i++) begin : g_cell
		logic c_in;    // Toggle this bit
		logic c_out;   // Propagate to the next bit

		if (i == 0) begin : g_lsb
			assign c_in = step;
		end else if (i == byte_w) begin : g_hi
			// Split mode forces the high byte to step on its own
			assign c_in = dec_split | (g_cell[i-1].c_in & g_cell[i-1].c_out);
		end else begin : g_rip
			assign c_in = g_cell[i-1].c_in & g_cell[i-1].c_out;
		end

		assign c_out       = operand[i] ? dec_inc : dec_dec;   // 1 carries up, 0 borrows down
		assign step_val[i] = operand[i] ^ c_in;
	end

	always_ff @(posedge clk4 or negedge arst_n) begin
		if (!arst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	// Result with pass-through fields
	always_ff @(posedge clk4) begin
		ex_pair    <= dec_pair;
		ex_value   <= step_val;
		ex_addr    <= dec_addr;
		ex_operand <= operand;    // Pre-step value, the address for HL ops
	end

	// Split is only defined as an increment
	a_split_inc: assert property (@(posedge clk4) disable iff (!arst_n)
		dec_valid && dec_split |-> dec_inc);

endmodule

/* design/idu_decode.sv */
module idu_decode (
	input  logic                         clk4,
	input  logic                         arst_n,
	input  logic                         cmd_valid,
	input  logic [idu_pkg::op_w-1:0]     cmd_op,
	input  logic [idu_pkg::word_w-1:0]   cmd_data,
	output logic [idu_pkg::pair_w-1:0]   rd_pair,
	input  logic [idu_pkg::word_w-1:0]   rd_value,
	input  logic                         ex_valid,
	input  logic [idu_pkg::pair_w-1:0]   ex_pair,
	input  logic [idu_pkg::word_w-1:0]   ex_value,
	input  logic                         res_valid,
	input  logic [idu_pkg::pair_w-1:0]   res_pair,
	input  logic [idu_pkg::word_w-1:0]   res_value,
	output logic                         dec_valid,
	output logic [idu_pkg::pair_w-1:0]   dec_pair,
	output logic [idu_pkg::word_w-1:0]   dec_operand,
	output logic                         dec_inc,
	output logic                         dec_dec,
	output logic                         dec_split,
	output logic                         dec_addr,
	output logic                         cmd_err
);
	import idu_pkg::*;

	logic              is_ld;      // LD rr,nn
	logic              is_inc;     // INC rr
	logic              is_dec;     // DEC rr
	logic              is_split;   // SPLIT INC rr
	logic              is_hli;     // LD (HL+)
	logic              is_hld;     // LD (HL-)
	logic              is_hl;
	logic              legal;
	logic [word_w-1:0] pair_val;   // Pair content after forwarding

	// Bits 5:4 carry the pair, every other bit must equal the base
	function automatic logic rr_match(input logic [op_w-1:0] op, input logic [op_w-1:0] base);
		return {op[7:6], op[3:0]} == {base[7:6], base[3:0]};
	endfunction

	assign is_ld    = rr_match(cmd_op, op_ld_rr);
	assign is_inc   = rr_match(cmd_op, op_inc_rr);
	assign is_dec   = rr_match(cmd_op, op_dec_rr);
	assign is_split = rr_match(cmd_op, op_split_inc);
	assign is_hli   = (cmd_op == op_ld_hli);
	assign is_hld   = (cmd_op == op_ld_hld);
	assign is_hl    = is_hli | is_hld;
	assign legal    = is_ld | is_inc | is_dec | is_split | is_hl;

	assign rd_pair = is_hl ? pair_hl : cmd_op[5:4];   // HL ops always address HL

	// Forwarding, youngest first
	// The command just ahead is still in decode, count picks that one up
	always_comb begin
		if (ex_valid && ex_pair == rd_pair)
			pair_val = ex_value;     // Two ahead, not yet written
		else if (res_valid && res_pair == rd_pair)
			pair_val = res_value;    // Three ahead, written this cycle
		else
			pair_val = rd_value;
	end

	// Step controls and strobes
	always_ff @(posedge clk4 or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
			cmd_err   <= 1'b0;
			dec_inc   <= 1'b0;
			dec_dec   <= 1'b0;
			dec_split <= 1'b0;
			dec_addr  <= 1'b0;
		end else begin
			dec_valid <= cmd_valid & legal;
			cmd_err   <= cmd_valid & ~legal;     // Illegal op, no result follows
			dec_inc   <= is_inc | is_split | is_hli;
			dec_dec   <= is_dec | is_hld;
			dec_split <= is_split;
			dec_addr  <= is_hl;                  // Pre-step HL goes out as address
		end
	end

	// Payload
	always_ff @(posedge clk4) begin
		dec_pair    <= rd_pair;
		dec_operand <= is_ld ? cmd_data : pair_val;   // LD passes the immediate
	end

	// Inc and dec selects never overlap, else the chain mixes both steps
	a_step_excl: assert property (@(posedge clk4) disable iff (!arst_n)
		$onehot0({dec_inc, dec_dec}));

endmodule

/* design/idu_pkg.sv */
package idu_pkg;

	// Datapath widths
	localparam int word_w = 16;   // One register pair
	localparam int byte_w = 8;    // Half of a pair, the split boundary
	localparam int op_w   = 8;    // Opcode byte
	localparam int pair_w = 2;    // Pair select

	// Pair indices, same order as the opcode field in bits 5:4
	localparam logic [pair_w-1:0] pair_bc = 2'd0;
	localparam logic [pair_w-1:0] pair_de = 2'd1;
	localparam logic [pair_w-1:0] pair_hl = 2'd2;
	localparam logic [pair_w-1:0] pair_sp = 2'd3;

	// Base opcodes of the rr group
	// Pair field in bits 5:4 is zero here, the rest must match exactly
	localparam logic [op_w-1:0] op_ld_rr     = 8'h01;   // LD rr,nn
	localparam logic [op_w-1:0] op_inc_rr    = 8'h03;   // INC rr
	localparam logic [op_w-1:0] op_dec_rr    = 8'h0B;   // DEC rr
	localparam logic [op_w-1:0] op_split_inc = 8'h04;   // Both bytes plus one, no carry

	// HL address ops, full byte compare
	localparam logic [op_w-1:0] op_ld_hli = 8'h22;   // LD (HL+)
	localparam logic [op_w-1:0] op_ld_hld = 8'h32;   // LD (HL-)

endpackage

/* design/idu_regfile.sv */
module idu_regfile (
	input  logic                         clk4,
	input  logic                         arst_n,
	input  logic [idu_pkg::pair_w-1:0]   rd_pair,
	output logic [idu_pkg::word_w-1:0]   rd_value,
	input  logic                         ex_valid,
	input  logic [idu_pkg::pair_w-1:0]   ex_pair,
	input  logic [idu_pkg::word_w-1:0]   ex_value,
	input  logic                         ex_addr,
	input  logic [idu_pkg::word_w-1:0]   ex_operand,
	output logic                         res_valid,
	output logic [idu_pkg::pair_w-1:0]   res_pair,
	output logic [idu_pkg::word_w-1:0]   res_value,
	output logic                         addr_valid,
	output logic [idu_pkg::word_w-1:0]   addr
);
	import idu_pkg::*;

	logic [word_w-1:0] pairs [pair_bc:pair_sp];   // BC, DE, HL, SP

	assign rd_value = pairs[rd_pair];   // Read port for decode

	// Pairs start at zero
	always_ff @(posedge clk4 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = pair_bc; i <= pair_sp; i++)
				pairs[i] <= '0;
			res_valid  <= 1'b0;
			addr_valid <= 1'b0;
		end else begin
			if (ex_valid)
				pairs[ex_pair] <= ex_value;
			res_valid  <= ex_valid;
			addr_valid <= ex_valid & ex_addr;   // HL ops only
		end
	end

	always_ff @(posedge clk4) begin
		res_pair  <= ex_pair;
		res_value <= ex_value;
		addr      <= ex_operand;   // Old HL
	end

	// Only HL commands put a value on the address port
	a_addr_hl: assert property (@(posedge clk4) disable iff (!arst_n)
		addr_valid |-> res_valid && res_pair == pair_hl);

endmodule

/* design/idu_top.sv */
module idu_top (
	input  logic                         clk4,
	input  logic                         arst_n,
	input  logic                         cmd_valid,
	input  logic [idu_pkg::op_w-1:0]     cmd_op,
	input  logic [idu_pkg::word_w-1:0]   cmd_data,
	output logic                         res_valid,
	output logic [idu_pkg::pair_w-1:0]   res_pair,
	output logic [idu_pkg::word_w-1:0]   res_value,
	output logic                         addr_valid,
	output logic [idu_pkg::word_w-1:0]   addr,
	output logic                         cmd_err
);
	import idu_pkg::*;

	// Regfile read port
	logic [pair_w-1:0] rd_pair;
	logic [word_w-1:0] rd_value;

	// Decode stage
	logic              dec_valid;
	logic [pair_w-1:0] dec_pair;
	logic [word_w-1:0] dec_operand;
	logic              dec_inc;
	logic              dec_dec;
	logic              dec_split;
	logic              dec_addr;

	// Count stage
	logic              ex_valid;
	logic [pair_w-1:0] ex_pair;
	logic [word_w-1:0] ex_value;
	logic              ex_addr;
	logic [word_w-1:0] ex_operand;

	idu_decode u_idu_decode (
		.clk4        (clk4),
		.arst_n      (arst_n),
		.cmd_valid   (cmd_valid),
		.cmd_op      (cmd_op),
		.cmd_data    (cmd_data),
		.rd_pair     (rd_pair),
		.rd_value    (rd_value),
		.ex_valid    (ex_valid),
		.ex_pair     (ex_pair),
		.ex_value    (ex_value),
		.res_valid   (res_valid),     // Write-back forward
		.res_pair    (res_pair),
		.res_value   (res_value),
		.dec_valid   (dec_valid),
		.dec_pair    (dec_pair),
		.dec_operand (dec_operand),
		.dec_inc     (dec_inc),
		.dec_dec     (dec_dec),
		.dec_split   (dec_split),
		.dec_addr    (dec_addr),
		.cmd_err     (cmd_err)
	);

	idu_count u_idu_count (
		.clk4        (clk4),
		.arst_n      (arst_n),
		.dec_valid   (dec_valid),
		.dec_pair    (dec_pair),
		.dec_operand (dec_operand),
		.dec_inc     (dec_inc),
		.dec_dec     (dec_dec),
		.dec_split   (dec_split),
		.dec_addr    (dec_addr),
		.ex_valid    (ex_valid),
		.ex_pair     (ex_pair),
		.ex_value    (ex_value),
		.ex_addr     (ex_addr),
		.ex_operand  (ex_operand)
	);

	idu_regfile u_idu_regfile (
		.clk4        (clk4),
		.arst_n      (arst_n),
		.rd_pair     (rd_pair),
		.rd_value    (rd_value),
		.ex_valid    (ex_valid),
		.ex_pair     (ex_pair),
		.ex_value    (ex_value),
		.ex_addr     (ex_addr),
		.ex_operand  (ex_operand),
		.res_valid   (res_valid),
		.res_pair    (res_pair),
		.res_value   (res_value),
		.addr_valid  (addr_valid),
		.addr        (addr)
	);

endmodule

/* dv/idu_tb_table.svh */
// Columns: opcode, immediate, expected pair value after the command
// Illegal rows give no result, so their value column is unused
localparam int n_table = 28;

localparam logic [39:0] table_rows [n_table] = '{
	{8'h01, 16'h00FF, 16'h00FF},   // LD BC
	{8'h11, 16'h0100, 16'h0100},   // LD DE
	{8'h21, 16'hFFFF, 16'hFFFF},   // LD HL
	{8'h31, 16'h0000, 16'h0000},   // LD SP
	{8'h03, 16'h0000, 16'h0100},   // INC BC, carry into high byte
	{8'h1B, 16'hDEAD, 16'h00FF},   // DEC DE, borrow from high byte
	{8'h23, 16'h0000, 16'h0000},   // INC HL wraps to zero
	{8'h3B, 16'h0000, 16'hFFFF},   // DEC SP wraps to all ones
	{8'h01, 16'h12FF, 16'h12FF},   // LD BC
	{8'h04, 16'h0000, 16'h1300},   // SPLIT INC BC, low byte wraps alone
	{8'h04, 16'h0000, 16'h1401},   // Back to back on BC
	{8'h04, 16'hBEEF, 16'h1502},
	{8'h21, 16'hFFFE, 16'hFFFE},   // LD HL
	{8'h22, 16'h0000, 16'hFFFF},   // LD (HL+), addr FFFE
	{8'h22, 16'h0000, 16'h0000},   // addr FFFF
	{8'h32, 16'h0000, 16'hFFFF},   // LD (HL-), addr 0000
	{8'h32, 16'h0000, 16'hFFFE},   // addr FFFF
	{8'hFF, 16'h1234, 16'h0000},   // Illegal
	{8'h13, 16'h0000, 16'h0100},   // INC DE, every cycle
	{8'h13, 16'h0000, 16'h0101},
	{8'h1B, 16'h0000, 16'h0100},
	{8'h1B, 16'h0000, 16'h00FF},
	{8'h11, 16'hABCD, 16'hABCD},   // LD then DEC right behind it
	{8'h1B, 16'h0000, 16'hABCC},
	{8'h34, 16'h0000, 16'h0000},   // SPLIT INC SP, both bytes wrap
	{8'h00, 16'h5555, 16'h0000},   // Illegal
	{8'h13, 16'h0000, 16'hABCD},
	{8'h33, 16'h0000, 16'h0001}    // SP untouched by the illegal ops
};

/* dv/idu_tb.sv */
module idu_tb;
	import idu_pkg::*;

	`include "idu_tb_table.svh"

	localparam int n_rand = 64;
	localparam int run_limit = (n_table + n_rand) * 2 + 40;   // Cycles before timeout
	localparam logic [op_w-1:0] op_illegal = 8'hFF;

	logic              clk4 = 1'b0;
	logic              arst_n;
	logic              cmd_valid;
	logic [op_w-1:0]   cmd_op;
	logic [word_w-1:0] cmd_data;
	logic              res_valid;
	logic [pair_w-1:0] res_pair;
	logic [word_w-1:0] res_value;
	logic              addr_valid;
	logic [word_w-1:0] addr;
	logic              cmd_err;

	int cyc = 0;          // Rising edges so far
	int mismatches = 0;
	int failures = 0;     // Missing or stray strobes
	bit checking = 1'b0;

	logic [word_w-1:0] model_pairs [4];   // Reference BC, DE, HL, SP

	// Expected results, oldest first
	int                res_due[$];
	logic [pair_w-1:0] exp_pair_q[$];
	logic [word_w-1:0] exp_value_q[$];
	bit                exp_hl_q[$];
	logic [word_w-1:0] exp_addr_q[$];
	int                err_due[$];

	idu_top u_idu_top (
		.clk4       (clk4),
		.arst_n     (arst_n),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_data   (cmd_data),
		.res_valid  (res_valid),
		.res_pair   (res_pair),
		.res_value  (res_value),
		.addr_valid (addr_valid),
		.addr       (addr),
		.cmd_err    (cmd_err)
	);

	always #2 clk4 = ~clk4;

	always @(posedge clk4) begin
		cyc <= cyc + 1;
		if (cyc >= run_limit) begin
			$display("Timeout: run still busy after %0d cycles", run_limit);
			$display("test failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// Pair field in bits 5:4, the rest names the command
	task automatic model_step(input logic [op_w-1:0] op, input logic [word_w-1:0] data,
			output bit legal, output logic [pair_w-1:0] pair,
			output logic [word_w-1:0] value, output bit hl, output logic [word_w-1:0] old);
		logic [op_w-1:0] base;
		base = op & 8'hCF;
		legal = 1'b1;
		hl = 1'b0;
		pair = op[5:4];
		if (op == op_ld_hli || op == op_ld_hld) begin
			pair = pair_hl;
			hl = 1'b1;
		end
		old = model_pairs[pair];
		if (hl)
			value = (op == op_ld_hli) ? old + 16'd1 : old - 16'd1;
		else if (base == op_ld_rr)
			value = data;
		else if (base == op_inc_rr)
			value = old + 16'd1;
		else if (base == op_dec_rr)
			value = old - 16'd1;
		else if (base == op_split_inc)
			value = {old[15:8] + 8'd1, old[7:0] + 8'd1};   // No carry between bytes
		else begin
			legal = 1'b0;
			value = old;
		end
		if (legal)
			model_pairs[pair] = value;
	endtask

	// Called on a falling edge, strobe lands on the next rising edge
	task automatic send_command(input logic [op_w-1:0] op, input logic [word_w-1:0] data,
			input bit from_table, input logic [word_w-1:0] table_exp, input int row);
		bit                legal;
		bit                hl;
		logic [pair_w-1:0] pair;
		logic [word_w-1:0] value;
		logic [word_w-1:0] old;
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_data  = data;
		model_step(op, data, legal, pair, value, hl, old);
		if (!legal) begin
			err_due.push_back(cyc + 1);   // One cycle after the strobe
		end else begin
			if (from_table && value !== table_exp) begin
				failures++;
				$display("Table row %0d expects %h but the model gives %h", row, table_exp, value);
			end
			res_due.push_back(cyc + 3);   // Three cycles after the strobe
			exp_pair_q.push_back(pair);
			exp_value_q.push_back(from_table ? table_exp : value);
			exp_hl_q.push_back(hl);
			exp_addr_q.push_back(old);
		end
	endtask

	function automatic logic [op_w-1:0] random_op(input logic [31:0] r);
		logic [op_w-1:0] pf;
		pf = {2'b00, r[9:8], 4'b0000};
		case (r % 7)
			0:       return op_ld_rr | pf;
			1:       return op_inc_rr | pf;
			2:       return op_dec_rr | pf;
			3:       return op_split_inc | pf;
			4:       return op_ld_hli;
			5:       return op_ld_hld;
			default: return op_illegal;
		endcase
	endfunction

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk4) begin
		if (checking) begin
			if (res_valid) begin
				if (res_due.size() == 0) begin
					failures++;
					$display("Unexpected res_valid at %0t with no command pending", $time);
				end else begin
					compare_value("res_cycle", cyc, res_due.pop_front());
					compare_value("res_pair", 32'(res_pair), 32'(exp_pair_q.pop_front()));
					compare_value("res_value", 32'(res_value), 32'(exp_value_q.pop_front()));
					compare_value("addr_valid", 32'(addr_valid), 32'(exp_hl_q[0]));
					if (exp_hl_q.pop_front())
						compare_value("addr", 32'(addr), 32'(exp_addr_q[0]));
					void'(exp_addr_q.pop_front());
				end
			end else begin
				if (addr_valid) begin
					failures++;
					$display("addr_valid raised at %0t without res_valid", $time);
				end
				if (res_due.size() != 0 && res_due[0] <= cyc) begin
					failures++;
					$display("Missing res_valid at %0t for pair %0d", $time, exp_pair_q[0]);
					void'(res_due.pop_front());
					void'(exp_pair_q.pop_front());
					void'(exp_value_q.pop_front());
					void'(exp_hl_q.pop_front());
					void'(exp_addr_q.pop_front());
				end
			end
			if (cmd_err) begin
				if (err_due.size() == 0) begin
					failures++;
					$display("Unexpected cmd_err at %0t for a legal command", $time);
				end else begin
					compare_value("cmd_err_cycle", cyc, err_due.pop_front());
				end
			end else if (err_due.size() != 0 && err_due[0] <= cyc) begin
				failures++;
				$display("Missing cmd_err at %0t after an illegal opcode", $time);
				void'(err_due.pop_front());
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		arst_n    = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = '0;
		cmd_data  = '0;
		rnd       = 32'd62;   // Seed
		for (int p = 0; p < 4; p++)
			model_pairs[p] = '0;
		repeat (4) @(negedge clk4);
		arst_n   = 1'b1;
		checking = 1'b1;
		for (int i = 0; i < n_table; i++) begin   // Directed rows, one per cycle
			@(negedge clk4);
			send_command(table_rows[i][39:32], table_rows[i][31:16], 1'b1,
				table_rows[i][15:0], i);
		end
		for (int i = 0; i < n_rand; i++) begin
			rnd = xorshift(rnd);
			@(negedge clk4);
			send_command(random_op(rnd), rnd[31:16], 1'b0, '0, i);
		end
		@(negedge clk4);
		cmd_valid = 1'b0;
		cmd_op    = '0;
		cmd_data  = '0;
		while (res_due.size() != 0 || err_due.size() != 0)
			@(negedge clk4);
		repeat (4) @(negedge clk4);   // Stray strobes show up here
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* files.f */
+incdir+dv
design/idu_pkg.sv
design/idu_decode.sv
design/idu_count.sv
design/idu_regfile.sv
design/idu_top.sv
dv/idu_tb.sv
